//--- common/rv_isa_pkg.sv
`default_nettype none

// RISC-V encodings that the fetch path decodes for static prediction.
package rv_isa_pkg;

    // A fetched word. A compressed instruction sits in the low 16 bits.
    typedef logic [31:0] instr_word_t;

    // Unit of the instruction memory.
    typedef logic [15:0] halfword_t;

    typedef logic [6:0] opcode_t;
    typedef logic [1:0] c_quadrant_t;
    typedef logic [2:0] c_funct3_t;

    // Major opcodes of 32-bit instructions.
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // Quadrant 1 holds the compressed jumps and branches.
    localparam c_quadrant_t C_QUAD1 = 2'b01;

    // Function codes within quadrant 1.
    localparam c_funct3_t C_F3_J    = 3'b101;
    localparam c_funct3_t C_F3_BEQZ = 3'b110;
    localparam c_funct3_t C_F3_BNEZ = 3'b111;

endpackage

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

// Types used between the fetch controller, the memory and decode.
package fetch_pkg;

    typedef logic [31:0] pc_t;

    typedef logic [3:0] exc_code_t;

    // How the PC of a fetched item was reached.
    typedef enum logic [1:0] {
        IF_PREFETCH,
        IF_PREDICT,
        IF_MISPREDICT,
        IF_FLUSH
    } if_reason_t;

    // Instruction access fault.
    localparam exc_code_t EXC_INSTR_ACCESS = 4'd1;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        logic [31:0] tval;
    } exc_t;

    // Item handed to decode.
    typedef struct packed {
        rv_isa_pkg::instr_word_t instr_word;
        pc_t                     pc;
        if_reason_t              if_reason;
        exc_t                    exc;
    } fetched_instr_t;

    // Restart request from the back end. The valid bit is a one-cycle strobe.
    typedef struct packed {
        logic       valid;
        pc_t        pc;
        if_reason_t reason;
    } redirect_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } mem_req_t;

    typedef struct packed {
        logic                    valid;
        pc_t                     pc;
        rv_isa_pkg::instr_word_t instr_word;
        logic                    fault;
    } mem_resp_t;

    typedef enum logic [1:0] {
        FS_BOOT,
        FS_RUN,
        FS_FLUSH
    } fetch_state_t;

endpackage

`default_nettype wire

//--- fetcher/fetch_ctrl.sv
`default_nettype none

// Decides when the memory is asked for a word and which PC is asked for.
// Only one request is ever in flight.
module fetch_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  fetch_pkg::redirect_t  i_redirect,
    input  logic                  i_ready,
    input  logic                  i_resp_valid,
    input  fetch_pkg::pc_t        i_pred_pc,
    input  fetch_pkg::if_reason_t i_pred_reason,
    output fetch_pkg::mem_req_t   o_mem_req,
    output fetch_pkg::if_reason_t o_req_reason,
    output logic                  o_accept,
    output logic                  o_flush,
    output logic                  o_out_valid
);
    import fetch_pkg::*;

    fetch_state_t state_q;
    fetch_state_t state_d;
    redirect_t    redir_q;
    if_reason_t   req_reason_q;

    logic issue_redirect;
    logic issue_predict;

    // An item is live only in FS_RUN, and never in the cycle a redirect arrives.
    // A response that lands while flushing belongs to the old path.
    assign o_out_valid = i_resp_valid && (state_q == FS_RUN) && !i_redirect.valid;
    assign o_accept    = o_out_valid && i_ready;
    assign o_flush     = i_redirect.valid || (state_q == FS_FLUSH);

    // The pending redirect goes out one cycle after it was registered.
    // A newer redirect in the same cycle takes over and delays it by a cycle.
    assign issue_redirect = (state_q != FS_RUN) && redir_q.valid && !i_redirect.valid;

    // Each accepted item releases the request for its successor.
    assign issue_predict = o_accept;

    always_comb begin
        o_mem_req.valid = issue_redirect || issue_predict;
        if (issue_redirect) begin
            // Instructions are halfword aligned.
            o_mem_req.pc = {redir_q.pc[31:1], 1'b0};
        end else begin
            o_mem_req.pc = i_pred_pc;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            FS_BOOT, FS_FLUSH: begin
                if (issue_redirect) begin
                    state_d = FS_RUN;
                end
            end
            FS_RUN: begin
                state_d = FS_RUN;
            end
            default: begin
                state_d = FS_BOOT;
            end
        endcase
        if (i_redirect.valid) begin
            state_d = FS_FLUSH;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= FS_BOOT;
            // Boot behaves like a flush to the reset vector.
            redir_q <= '{valid: 1'b1, pc: '0, reason: IF_FLUSH};
            req_reason_q <= IF_FLUSH;
        end else begin
            state_q <= state_d;

            if (i_redirect.valid) begin
                redir_q <= i_redirect;
            end else if (issue_redirect) begin
                redir_q.valid <= 1'b0;
            end

            // The reason follows the request so it lines up with its response.
            if (issue_redirect) begin
                req_reason_q <= redir_q.reason;
            end else if (issue_predict) begin
                req_reason_q <= i_pred_reason;
            end
        end
    end

    assign o_req_reason = req_reason_q;

endmodule

`default_nettype wire

//--- fetcher/branch_predictor.sv
`default_nettype none

// Static next-PC selection for the item currently offered to decode.
// Backward conditional branches and all direct jumps are taken.
module branch_predictor #(
    parameter int BRANCH_PRED = 1
) (
    input  rv_isa_pkg::instr_word_t i_instr,
    input  fetch_pkg::pc_t          i_pc,
    output fetch_pkg::pc_t          o_next_pc,
    output fetch_pkg::if_reason_t   o_next_reason
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    logic is_branch;
    logic is_jal;
    logic is_c_branch;
    logic is_c_j;

    pc_t b_imm;
    pc_t j_imm;
    pc_t cb_imm;
    pc_t cj_imm;

    logic pred_taken;
    pc_t  pred_target;
    pc_t  word_pc;
    pc_t  seq_pc;

    assign is_branch = i_instr[6:0] == OPC_BRANCH;
    assign is_jal    = i_instr[6:0] == OPC_JAL;

    assign is_c_branch = (i_instr[1:0] == C_QUAD1)
                       && ((i_instr[15:13] == C_F3_BEQZ) || (i_instr[15:13] == C_F3_BNEZ));
    assign is_c_j      = (i_instr[1:0] == C_QUAD1) && (i_instr[15:13] == C_F3_J);

    // Immediates sign extended to the PC width.
    assign b_imm  = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign j_imm  = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
    assign cb_imm = {{24{i_instr[12]}}, i_instr[6:5], i_instr[2], i_instr[11:10],
                     i_instr[4:3], 1'b0};
    assign cj_imm = {{21{i_instr[12]}}, i_instr[8], i_instr[10:9], i_instr[6], i_instr[7],
                     i_instr[2], i_instr[11], i_instr[5:3], 1'b0};

    always_comb begin
        pred_taken  = 1'b0;
        pred_target = seq_pc;
        if (BRANCH_PRED != 0) begin
            if (is_branch) begin
                // The sign bit of the offset decides the direction.
                pred_taken  = i_instr[31];
                pred_target = i_pc + b_imm;
            end else if (is_jal) begin
                pred_taken  = 1'b1;
                pred_target = i_pc + j_imm;
            end else if (is_c_branch) begin
                pred_taken  = i_instr[12];
                pred_target = i_pc + cb_imm;
            end else if (is_c_j) begin
                pred_taken  = 1'b1;
                pred_target = i_pc + cj_imm;
            end
        end
    end

    // One adder on the word address with bit 1 patched afterwards gives +2 or +4.
    assign word_pc = {i_pc[31:2], 2'b00} + 32'd4;

    always_comb begin
        seq_pc = word_pc;
        if (i_instr[1:0] == 2'b11) begin
            // Full-length instruction keeps its halfword offset.
            seq_pc[1] = i_pc[1];
        end else if (!i_pc[1]) begin
            seq_pc = {i_pc[31:2], 2'b10};
        end
    end

    assign o_next_pc     = pred_taken ? pred_target : seq_pc;
    assign o_next_reason = pred_taken ? IF_PREDICT : IF_PREFETCH;

endmodule

`default_nettype wire

//--- fetcher/resp_buffer.sv
`default_nettype none

// One-entry skid for a memory response that decode did not take.
// The held copy wins over the live response until it is accepted.
module resp_buffer (
    input  logic                 clk,
    input  logic                 resetn,
    input  fetch_pkg::mem_resp_t i_resp,
    input  logic                 i_accept,
    input  logic                 i_flush,
    output fetch_pkg::mem_resp_t o_item
);
    import fetch_pkg::*;

    logic      held_valid;
    mem_resp_t held_data;
    logic      capture;

    // Capture only a fresh response that is neither taken nor flushed.
    assign capture = i_resp.valid && !held_valid && !i_accept && !i_flush;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            held_valid <= 1'b0;
        end else if (i_flush || i_accept) begin
            held_valid <= 1'b0;
        end else if (capture) begin
            held_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_data <= i_resp;
        end
    end

    always_comb begin
        if (held_valid) begin
            o_item = held_data;
            o_item.valid = 1'b1;
        end else begin
            o_item = i_resp;
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_mem.sv
`default_nettype none

// Halfword-wide instruction store with a one-cycle read of two halfwords.
// Fetches starting beyond the last halfword report an access fault.
module instr_mem #(
    parameter int MEM_DEPTH_HW = 512
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 i_load_en,
    input  fetch_pkg::pc_t       i_load_addr,
    input  rv_isa_pkg::halfword_t i_load_data,
    input  fetch_pkg::mem_req_t  i_req,
    output fetch_pkg::mem_resp_t o_resp
);
    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int AW = (MEM_DEPTH_HW > 1) ? $clog2(MEM_DEPTH_HW) : 1;

    halfword_t mem [MEM_DEPTH_HW];

    pc_t           hw_idx;
    logic          lo_in;
    logic          hi_in;
    logic [AW-1:0] lo_addr;
    logic [AW-1:0] hi_addr;
    halfword_t     lo_hw;
    halfword_t     hi_hw;

    logic        resp_valid_q;
    pc_t         resp_pc_q;
    instr_word_t resp_word_q;
    logic        resp_fault_q;

    // Halfword index of the request.
    assign hw_idx = {1'b0, i_req.pc[31:1]};
    assign lo_in  = hw_idx < pc_t'(MEM_DEPTH_HW);
    assign hi_in  = (hw_idx + pc_t'(1)) < pc_t'(MEM_DEPTH_HW);

    assign lo_addr = hw_idx[AW-1:0];
    assign hi_addr = lo_addr + AW'(1);

    // Anything past the end reads as zero.
    assign lo_hw = lo_in ? mem[lo_addr] : '0;
    assign hi_hw = hi_in ? mem[hi_addr] : '0;

    always_ff @(posedge clk) begin
        if (i_load_en && (i_load_addr < pc_t'(MEM_DEPTH_HW))) begin
            mem[i_load_addr[AW-1:0]] <= i_load_data;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= i_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req.valid) begin
            resp_pc_q    <= i_req.pc;
            resp_word_q  <= {hi_hw, lo_hw};
            resp_fault_q <= !lo_in;
        end
    end

    assign o_resp = '{valid: resp_valid_q, pc: resp_pc_q,
                      instr_word: resp_word_q, fault: resp_fault_q};

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`default_nettype none

// Instruction fetch front end with controller, predictor, response skid and memory.
module fetch_top #(
    parameter int BRANCH_PRED  = 1,
    parameter int MEM_DEPTH_HW = 512
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  fetch_pkg::redirect_t     i_redirect,
    input  logic                     i_ready,
    input  logic                     i_load_en,
    input  fetch_pkg::pc_t           i_load_addr,
    input  rv_isa_pkg::halfword_t    i_load_data,
    output logic                     o_valid,
    output fetch_pkg::fetched_instr_t o_fetched_instr
);
    import fetch_pkg::*;

    mem_req_t   mem_req;
    mem_resp_t  mem_resp;
    mem_resp_t  item;
    if_reason_t req_reason;
    pc_t        pred_pc;
    if_reason_t pred_reason;
    logic       accept;
    logic       flush;

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .i_redirect   (i_redirect),
        .i_ready      (i_ready),
        .i_resp_valid (item.valid),
        .i_pred_pc    (pred_pc),
        .i_pred_reason(pred_reason),
        .o_mem_req    (mem_req),
        .o_req_reason (req_reason),
        .o_accept     (accept),
        .o_flush      (flush),
        .o_out_valid  (o_valid)
    );

    branch_predictor #(
        .BRANCH_PRED(BRANCH_PRED)
    ) u_pred (
        .i_instr      (item.instr_word),
        .i_pc         (item.pc),
        .o_next_pc    (pred_pc),
        .o_next_reason(pred_reason)
    );

    resp_buffer u_buf (
        .clk     (clk),
        .resetn  (resetn),
        .i_resp  (mem_resp),
        .i_accept(accept),
        .i_flush (flush),
        .o_item  (item)
    );

    instr_mem #(
        .MEM_DEPTH_HW(MEM_DEPTH_HW)
    ) u_mem (
        .clk        (clk),
        .resetn     (resetn),
        .i_load_en  (i_load_en),
        .i_load_addr(i_load_addr),
        .i_load_data(i_load_data),
        .i_req      (mem_req),
        .o_resp     (mem_resp)
    );

    // The only fault the front end raises is an access fault on the item's PC.
    assign o_fetched_instr.instr_word = item.instr_word;
    assign o_fetched_instr.pc         = item.pc;
    assign o_fetched_instr.if_reason  = req_reason;
    assign o_fetched_instr.exc.valid  = item.fault;
    assign o_fetched_instr.exc.code   = EXC_INSTR_ACCESS;
    assign o_fetched_instr.exc.tval   = item.pc;

endmodule

`default_nettype wire

//--- verif/tb_fetch.sv
`default_nettype none

// Directed testbench for the fetch front end.
// A reference model follows its own copy of the program and predicts every item.
module tb_fetch;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import fetch_pkg::*;

    localparam int MEM_DEPTH_HW    = 512;
    localparam int TOTAL_ITEMS     = 47;
    localparam int CYCLES_PER_ITEM = 40;

    logic           clk = 1'b0;
    logic           resetn;
    redirect_t      i_redirect;
    logic           i_ready;
    logic           i_load_en;
    pc_t            i_load_addr;
    halfword_t      i_load_data;
    logic           o_valid;
    fetched_instr_t o_fetched_instr;

    halfword_t      prog [MEM_DEPTH_HW];
    pc_t            exp_pc;
    if_reason_t     exp_reason;
    fetched_instr_t got_items[$];
    fetched_instr_t boot_items[$];

    int seed   = 32'h17c70f1f;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    fetch_top dut (
        .clk            (clk),
        .resetn         (resetn),
        .i_redirect     (i_redirect),
        .i_ready        (i_ready),
        .i_load_en      (i_load_en),
        .i_load_addr    (i_load_addr),
        .i_load_data    (i_load_data),
        .o_valid        (o_valid),
        .o_fetched_instr(o_fetched_instr)
    );

    always #10 clk = ~clk;

    initial begin
        repeat (MEM_DEPTH_HW + TOTAL_ITEMS * CYCLES_PER_ITEM) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("** FAIL **");
        $finish;
    end

    task automatic put_half(input pc_t addr, input halfword_t data);
        prog[int'(addr >> 1)] = data;
    endtask

    task automatic put_word(input pc_t addr, input instr_word_t data);
        prog[int'(addr >> 1)]     = data[15:0];
        prog[int'(addr >> 1) + 1] = data[31:16];
    endtask

    task automatic build_program();
        // Filler is a c.li whose fields carry the halfword index.
        for (int i = 0; i < MEM_DEPTH_HW; i++) begin
            prog[i] = {3'b010, 11'(i), 2'b01};
        end
        // Straight-line code with 32-bit words also at PCs that are 2 mod 4.
        put_word(32'h000, 32'h0010_0093);
        put_half(32'h004, 16'h0085);
        put_word(32'h006, 32'h0010_8133);
        put_half(32'h00a, 16'h0001);
        put_word(32'h00c, 32'h0020_8193);
        put_half(32'h010, 16'h8206);
        put_word(32'h012, 32'h0031_0213);
        put_half(32'h016, 16'h428d);
        put_word(32'h018, 32'h0000_0013);
        put_half(32'h01c, 16'h0001);
        // Control-flow loop.
        put_half(32'h100, 16'h0001);
        put_word(32'h102, 32'h0000_0463); // beq x0, x0, +8
        put_half(32'h106, 16'he011);      // c.bnez x8, +4
        put_word(32'h108, 32'h00c0_006f); // jal x0, +12
        put_word(32'h10c, 32'h0000_0013);
        put_half(32'h110, 16'h0001);
        put_half(32'h112, 16'hd47d);      // c.beqz x8, -18
        put_half(32'h114, 16'ha021);      // c.j +8
        put_word(32'h11c, 32'hfe00_98e3); // bne x1, x0, -16
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_DEPTH_HW; i++) begin
            @(posedge clk);
            i_load_en   <= 1'b1;
            i_load_addr <= pc_t'(i);
            i_load_data <= prog[i];
        end
        @(posedge clk);
        i_load_en <= 1'b0;
    endtask

    function automatic instr_word_t ref_word(input pc_t addr);
        int        idx;
        halfword_t lo;
        halfword_t hi;
        idx = int'(addr >> 1);
        lo  = (idx < MEM_DEPTH_HW) ? prog[idx] : '0;
        hi  = (idx + 1 < MEM_DEPTH_HW) ? prog[idx + 1] : '0;
        return {hi, lo};
    endfunction

    // Static prediction as the ISA encodings define the offsets.
    task automatic predict_next(input instr_word_t w, input pc_t addr,
                                output pc_t next_pc, output if_reason_t next_reason);
        pc_t  offset;
        logic taken;
        offset = '0;
        taken  = 1'b0;
        if (w[6:0] == OPC_BRANCH) begin
            offset = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            taken  = offset[31];
        end else if (w[6:0] == OPC_JAL) begin
            offset = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            taken  = 1'b1;
        end else if (w[1:0] == C_QUAD1 && (w[15:13] == C_F3_BEQZ || w[15:13] == C_F3_BNEZ)) begin
            offset = {{24{w[12]}}, w[6:5], w[2], w[11:10], w[4:3], 1'b0};
            taken  = offset[31];
        end else if (w[1:0] == C_QUAD1 && w[15:13] == C_F3_J) begin
            offset = {{21{w[12]}}, w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
            taken  = 1'b1;
        end
        if (taken) begin
            next_pc     = addr + offset;
            next_reason = IF_PREDICT;
        end else begin
            next_pc     = addr + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
            next_reason = IF_PREFETCH;
        end
    endtask

    task automatic check_fetch(input string what, input fetched_instr_t got,
                               input fetched_instr_t exp);
        if (got.instr_word !== exp.instr_word) begin
            $display("Error: %s o_fetched_instr.instr_word got %h expected %h",
                     what, got.instr_word, exp.instr_word);
            errors++;
        end
        if (got.pc !== exp.pc) begin
            $display("Error: %s o_fetched_instr.pc got %h expected %h", what, got.pc, exp.pc);
            errors++;
        end
        if (got.if_reason !== exp.if_reason) begin
            $display("Error: %s o_fetched_instr.if_reason at pc %h got %h expected %h",
                     what, exp.pc, got.if_reason, exp.if_reason);
            errors++;
        end
    endtask

    task automatic check_exc(input string what, input exc_t got, input exc_t exp);
        if (got !== exp) begin
            $display("Error: %s o_fetched_instr.exc got %h/%h/%h expected %h/%h/%h", what,
                     got.valid, got.code, got.tval, exp.valid, exp.code, exp.tval);
            errors++;
        end
    endtask

    // Runs until n items are accepted and checks each one against the model.
    task automatic collect(input int n, input bit random_ready);
        int             count;
        bit             first;
        bit             held;
        fetched_instr_t held_item;
        fetched_instr_t exp;
        count = 0;
        first = 1'b1;
        held  = 1'b0;
        got_items.delete();
        while (count < n) begin
            @(posedge clk);
            i_ready <= random_ready ? 1'($random(seed)) : 1'b1;
            @(negedge clk);
            if (first && !o_valid) begin
                $display("First item did not arrive in the cycle it was due");
                errors++;
            end
            first = 1'b0;
            if (held && !o_valid) begin
                $display("o_valid dropped while a stalled item waited for decode");
                errors++;
            end else if (held) begin
                check_fetch("stalled item", o_fetched_instr, held_item);
                check_exc("stalled item", o_fetched_instr.exc, held_item.exc);
            end
            if (o_valid && i_ready) begin
                exp.instr_word = ref_word(exp_pc);
                exp.pc         = exp_pc;
                exp.if_reason  = exp_reason;
                exp.exc.valid  = (exp_pc >> 1) >= pc_t'(MEM_DEPTH_HW);
                exp.exc.code   = EXC_INSTR_ACCESS;
                exp.exc.tval   = exp_pc;
                check_fetch("item", o_fetched_instr, exp);
                check_exc("item", o_fetched_instr.exc, exp.exc);
                got_items.push_back(o_fetched_instr);
                predict_next(exp.instr_word, exp_pc, exp_pc, exp_reason);
                held = 1'b0;
                count++;
            end else if (o_valid) begin
                held      = 1'b1;
                held_item = o_fetched_instr;
            end
        end
    endtask

    // A redirect blanks the redirect cycle and the next one.
    task automatic redirect_to(input pc_t target, input if_reason_t reason);
        @(posedge clk);
        i_redirect <= '{valid: 1'b1, pc: target, reason: reason};
        @(negedge clk);
        if (o_valid) begin
            $display("o_valid was high in the redirect cycle");
            errors++;
        end
        @(posedge clk);
        i_redirect <= '0;
        @(negedge clk);
        if (o_valid) begin
            $display("o_valid was high in the cycle after a redirect");
            errors++;
        end
        exp_pc     = {target[31:1], 1'b0};
        exp_reason = reason;
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("Test %0d %s: passed", num, name);
        end else begin
            failed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errors - errors_before);
        end
    endtask

    task automatic test_boot();
        int e0;
        e0         = errors;
        exp_pc     = '0;
        exp_reason = IF_FLUSH;
        collect(10, 1'b0);
        boot_items = got_items;
        report_test(1, "boot and sequential fetch", e0);
    endtask

    task automatic test_predict();
        int e0;
        e0 = errors;
        redirect_to(32'h100, IF_FLUSH);
        collect(12, 1'b0);
        report_test(2, "static prediction", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        e0 = errors;
        redirect_to(32'h000, IF_FLUSH);
        collect(10, 1'b1);
        foreach (boot_items[k]) begin
            check_fetch("replayed item", got_items[k], boot_items[k]);
        end
        report_test(3, "back-pressure", e0);
    endtask

    task automatic test_redirect();
        int e0;
        e0 = errors;
        redirect_to(32'h000, IF_FLUSH);
        collect(4, 1'b0);
        redirect_to(32'h10d, IF_MISPREDICT);
        collect(5, 1'b0);
        report_test(4, "mid-stream redirect", e0);
    endtask

    task automatic test_fault();
        int e0;
        e0 = errors;
        redirect_to(32'h1000, IF_MISPREDICT);
        collect(3, 1'b0);
        // Start at the last halfword in range and run into the fault boundary.
        redirect_to(32'h3fe, IF_FLUSH);
        collect(3, 1'b0);
        report_test(5, "access fault", e0);
    endtask

    initial begin
        resetn      = 1'b0;
        i_redirect  = '0;
        i_ready     = 1'b0;
        i_load_en   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        build_program();
        load_program();
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        test_boot();
        test_predict();
        test_backpressure();
        test_redirect();
        test_fault();
        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/rv_isa_pkg.sv
common/fetch_pkg.sv
fetcher/fetch_ctrl.sv
fetcher/branch_predictor.sv
fetcher/resp_buffer.sv
hw/instr_mem.sv
hw/fetch_top.sv
verif/tb_fetch.sv

//--- Makefile
# Verilator flow for the fetch front end.
TOP := tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
